//--- hdl/epb_opb_params.svh
`ifndef EPB_OPB_PARAMS_SVH
`define EPB_OPB_PARAMS_SVH

// number of 32-bit registers in the slave
`define REG_DEPTH 64

// wait cycles between select seen by the slave and its acknowledge
`define SLV_WAIT 2

// select cycles without an acknowledge before the bus times out
`define OPB_TIMEOUT_CYC 16

// idle cycles the bridge adds after each reply
`define BRIDGE_BACKOFF 2

`endif

//--- hdl/epb_opb_pkg.sv
`default_nettype none

package epb_opb_pkg;

  // OPB vectors are big-endian, bit 0 is the msb
  typedef logic [0:31] opb_addr_t;
  typedef logic [0:31] opb_data_t;
  typedef logic [0:3]  opb_be_t;

  // the EPB side keeps the usual descending order
  typedef logic [15:0] epb_data_t;

  // bridge request sequencing
  typedef enum logic [1:0] {
    BR_IDLE    = 2'd0,
    BR_ARB     = 2'd1,
    BR_WAIT    = 2'd2,
    BR_BACKOFF = 2'd3
  } bridge_state_e;

endpackage

`default_nettype wire

//--- hdl/epb_opb_bridge.sv
`timescale 1ns/1ps
`default_nettype none
`include "epb_opb_params.svh"

module epb_opb_bridge (
  input  wire                          OPB_Clk,
  input  wire                          arst_n,
  input  wire                          epb_cs_n,
  input  wire                          epb_r_w_n,
  input  wire                          epb_oe_n,
  input  wire  [1:0]                   epb_be_n,
  input  wire  [22:0]                  epb_addr,
  input  wire  [5:0]                   epb_addr_gp,
  input  wire  epb_opb_pkg::epb_data_t epb_data_i,
  output epb_opb_pkg::epb_data_t       epb_data_o,
  output logic                         epb_data_oe_n,
  output logic                         epb_rdy,
  output logic                         m_request,
  output logic                         m_select,
  output logic                         m_rnw,
  output epb_opb_pkg::opb_be_t         m_be,
  output epb_opb_pkg::opb_addr_t       m_abus,
  output epb_opb_pkg::opb_data_t       m_dbus,
  input  wire                          opb_mgrant,
  input  wire                          opb_xferack,
  input  wire                          opb_errack,
  input  wire                          opb_timeout,
  input  wire  epb_opb_pkg::opb_data_t opb_dbus
);

  import epb_opb_pkg::*;

  localparam int BO_W = $clog2(`BRIDGE_BACKOFF + 2);

  bridge_state_e   state;
  logic            prev_cs_n;
  logic            sel_q;
  logic            pend_q;
  logic [BO_W-1:0] backoff_cnt;
  logic            strobe;
  logic            active;
  logic            reply;

  // falling edge of cs_n as seen on the bus clock
  assign strobe = prev_cs_n & ~epb_cs_n;
  assign active = ~epb_cs_n;
  assign reply  = opb_xferack | opb_errack | opb_timeout;

  // host data pins turn around only for a read with oe_n low
  assign epb_data_oe_n = ~epb_r_w_n | epb_cs_n | epb_oe_n;

  // request spans from the strobe to the end of the wait state
  assign m_request = (state == BR_IDLE && strobe) ||
                     state == BR_ARB ||
                     state == BR_WAIT;

  // select cuts through as soon as the grant is there
  assign m_select = sel_q ||
                    (state == BR_IDLE && strobe && opb_mgrant) ||
                    (state == BR_ARB && active && opb_mgrant);

  // ready and read data cut through from the reply
  assign epb_rdy    = (state == BR_WAIT) && reply;
  assign epb_data_o = epb_addr[0] ? opb_dbus[16:31] : opb_dbus[0:15];

  // master bus is all zero while not selected so the arbiter can OR it
  always_comb begin
    m_rnw  = 1'b0;
    m_be   = '0;
    m_abus = '0;
    m_dbus = '0;
    if (m_select) begin
      m_rnw  = epb_r_w_n;
      // word address, upper 3 group bits select the region
      m_abus = {5'b0, epb_addr_gp[2:0], epb_addr[22:1], 2'b00};
      if (epb_addr[0]) begin
        // odd half-word rides on the low lanes
        if (epb_r_w_n) begin
          m_be = 4'b0011;
        end else begin
          m_be   = {2'b00, ~epb_be_n[1], ~epb_be_n[0]};
          m_dbus = {16'h0000, epb_data_i};
        end
      end else begin
        if (epb_r_w_n) begin
          m_be = 4'b1100;
        end else begin
          m_be   = {~epb_be_n[1], ~epb_be_n[0], 2'b00};
          m_dbus = {epb_data_i, 16'h0000};
        end
      end
    end
  end

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= BR_IDLE;
      prev_cs_n   <= 1'b1;
      sel_q       <= 1'b0;
      pend_q      <= 1'b0;
      backoff_cnt <= '0;
    end else begin
      prev_cs_n <= epb_cs_n;
      case (state)
        BR_IDLE: begin
          if (strobe) begin
            if (opb_mgrant) begin
              sel_q <= 1'b1;
              state <= BR_WAIT;
            end else begin
              state <= BR_ARB;
            end
          end
        end
        BR_ARB: begin
          // host gave up before the grant came
          if (!active) begin
            state <= BR_IDLE;
          end else if (opb_mgrant) begin
            sel_q <= 1'b1;
            state <= BR_WAIT;
          end
        end
        BR_WAIT: begin
          if (reply) begin
            sel_q       <= 1'b0;
            pend_q      <= 1'b0;
            backoff_cnt <= BO_W'(`BRIDGE_BACKOFF);
            state       <= BR_BACKOFF;
          end else if (!active) begin
            sel_q <= 1'b0;
            state <= BR_IDLE;
          end
        end
        BR_BACKOFF: begin
          // remember a strobe that lands during backoff
          if (strobe) begin
            pend_q <= 1'b1;
          end
          if (backoff_cnt != '0) begin
            backoff_cnt <= backoff_cnt - 1'b1;
          end else begin
            pend_q <= 1'b0;
            if ((pend_q || strobe) && active) begin
              state <= BR_ARB;
            end else begin
              state <= BR_IDLE;
            end
          end
        end
        default: begin
          state <= BR_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/opb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "epb_opb_params.svh"

module opb_arbiter (
  input  wire                          OPB_Clk,
  input  wire                          arst_n,
  input  wire                          m0_request,
  input  wire                          m0_select,
  input  wire                          m0_rnw,
  input  wire  epb_opb_pkg::opb_be_t   m0_be,
  input  wire  epb_opb_pkg::opb_addr_t m0_abus,
  input  wire  epb_opb_pkg::opb_data_t m0_dbus,
  output logic                         m0_mgrant,
  input  wire                          m1_request,
  input  wire                          m1_select,
  input  wire                          m1_rnw,
  input  wire  epb_opb_pkg::opb_be_t   m1_be,
  input  wire  epb_opb_pkg::opb_addr_t m1_abus,
  input  wire  epb_opb_pkg::opb_data_t m1_dbus,
  output logic                         m1_mgrant,
  input  wire                          slv_xferack,
  input  wire                          slv_errack,
  input  wire  epb_opb_pkg::opb_data_t slv_dbus,
  output logic                         bus_select,
  output logic                         bus_rnw,
  output epb_opb_pkg::opb_be_t         bus_be,
  output epb_opb_pkg::opb_addr_t       bus_abus,
  output epb_opb_pkg::opb_data_t       bus_dbus,
  output logic                         opb_xferack,
  output logic                         opb_errack,
  output epb_opb_pkg::opb_data_t       opb_dbus,
  output logic                         opb_timeout
);

  import epb_opb_pkg::*;

  localparam int TO_W = $clog2(`OPB_TIMEOUT_CYC + 1);

  logic            owner_q;
  logic            owner_d;
  logic            owner_sel;
  logic            ack;
  logic [TO_W-1:0] to_cnt;

  // owner_q low means master 0 holds the grant
  assign owner_sel = owner_q ? m1_select : m0_select;

  // hand over only while the owner is off the bus, master 1 first
  always_comb begin
    owner_d = owner_q;
    if (!owner_sel) begin
      if (m1_request) begin
        owner_d = 1'b1;
      end else if (m0_request) begin
        owner_d = 1'b0;
      end
    end
  end

  assign m0_mgrant = ~owner_q;
  assign m1_mgrant = owner_q;

  // idle masters drive zeros, so OR is the bus
  assign bus_select = m0_select | m1_select;
  assign bus_rnw    = m0_rnw | m1_rnw;
  assign bus_be     = m0_be | m1_be;
  assign bus_abus   = m0_abus | m1_abus;
  assign bus_dbus   = m0_dbus | m1_dbus;

  // reply path back to both masters
  assign opb_xferack = slv_xferack;
  assign opb_errack  = slv_errack;
  assign opb_dbus    = slv_dbus;

  assign ack = slv_xferack | slv_errack;

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      owner_q     <= 1'b0;
      to_cnt      <= '0;
      opb_timeout <= 1'b0;
    end else begin
      owner_q <= owner_d;
      // single pulse after the full count of unanswered select cycles
      opb_timeout <= bus_select && !ack && (to_cnt == TO_W'(`OPB_TIMEOUT_CYC - 1));
      if (!bus_select || ack) begin
        to_cnt <= '0;
      end else if (to_cnt != TO_W'(`OPB_TIMEOUT_CYC)) begin
        to_cnt <= to_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/opb_reg_slave.sv
`timescale 1ns/1ps
`default_nettype none
`include "epb_opb_params.svh"

module opb_reg_slave (
  input  wire                          OPB_Clk,
  input  wire                          arst_n,
  input  wire                          bus_select,
  input  wire                          bus_rnw,
  input  wire  epb_opb_pkg::opb_be_t   bus_be,
  input  wire  epb_opb_pkg::opb_addr_t bus_abus,
  input  wire  epb_opb_pkg::opb_data_t bus_dbus,
  output logic                         slv_xferack,
  output logic                         slv_errack,
  output epb_opb_pkg::opb_data_t       slv_dbus
);

  import epb_opb_pkg::*;

  localparam int IDX_W    = $clog2(`REG_DEPTH);
  localparam int CNT_W    = $clog2(`SLV_WAIT + 3);
  localparam int REPLY_AT = `SLV_WAIT + 1;

  opb_data_t        regs [`REG_DEPTH];
  logic [21:0]      word;
  logic [IDX_W-1:0] idx;
  logic             region_hit;
  logic             in_range;
  logic             reply_cyc;
  logic [CNT_W-1:0] wait_cnt;

  // address layout: region in bits 0..7, word index in 8..29
  assign region_hit = (bus_abus[0:7] == 8'h00);
  assign word       = bus_abus[8:29];
  assign idx        = word[IDX_W-1:0];
  assign in_range   = (word < 22'(`REG_DEPTH));

  // reply lands once the wait count is used up
  assign reply_cyc   = bus_select && region_hit && (wait_cnt == CNT_W'(REPLY_AT));
  assign slv_xferack = reply_cyc && in_range;
  assign slv_errack  = reply_cyc && !in_range;

  // unmapped words answer with zero data
  assign slv_dbus = (slv_xferack && bus_rnw) ? regs[idx] : '0;

  // counter stops past the reply so a long select gets one answer
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      wait_cnt <= '0;
    end else if (!bus_select) begin
      wait_cnt <= '0;
    end else if (region_hit && wait_cnt <= CNT_W'(REPLY_AT)) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // byte lane b covers bus bits 8*b to 8*b+7
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `REG_DEPTH; i++) begin
        regs[i] <= '0;
      end
    end else if (slv_xferack && !bus_rnw) begin
      for (int b = 0; b < 4; b++) begin
        if (bus_be[b]) begin
          regs[idx][8*b +: 8] <= bus_dbus[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/epb_opb_top.sv
`timescale 1ns/1ps
`default_nettype none

module epb_opb_top (
  input  wire                          OPB_Clk,
  input  wire                          arst_n,
  input  wire                          epb_cs_n,
  input  wire                          epb_r_w_n,
  input  wire                          epb_oe_n,
  input  wire  [1:0]                   epb_be_n,
  input  wire  [22:0]                  epb_addr,
  input  wire  [5:0]                   epb_addr_gp,
  input  wire  epb_opb_pkg::epb_data_t epb_data_i,
  output epb_opb_pkg::epb_data_t       epb_data_o,
  output logic                         epb_data_oe_n,
  output logic                         epb_rdy,
  input  wire                          m1_request,
  input  wire                          m1_select,
  input  wire                          m1_rnw,
  input  wire  epb_opb_pkg::opb_be_t   m1_be,
  input  wire  epb_opb_pkg::opb_addr_t m1_abus,
  input  wire  epb_opb_pkg::opb_data_t m1_dbus,
  output logic                         m1_mgrant,
  output logic                         m1_xferack,
  output logic                         m1_errack,
  output logic                         m1_timeout,
  output epb_opb_pkg::opb_data_t       m1_dbus_rd
);

  import epb_opb_pkg::*;

  // bridge master bus
  logic      m0_request;
  logic      m0_select;
  logic      m0_rnw;
  opb_be_t   m0_be;
  opb_addr_t m0_abus;
  opb_data_t m0_dbus;
  logic      m0_mgrant;

  // combined bus toward the slave
  logic      bus_select;
  logic      bus_rnw;
  opb_be_t   bus_be;
  opb_addr_t bus_abus;
  opb_data_t bus_dbus;

  // slave reply and the shared return path
  logic      slv_xferack;
  logic      slv_errack;
  opb_data_t slv_dbus;
  logic      opb_xferack;
  logic      opb_errack;
  logic      opb_timeout;
  opb_data_t opb_dbus;

  assign m1_xferack = opb_xferack;
  assign m1_errack  = opb_errack;
  assign m1_timeout = opb_timeout;
  assign m1_dbus_rd = opb_dbus;

  epb_opb_bridge u_bridge (
    .OPB_Clk       (OPB_Clk),
    .arst_n        (arst_n),
    .epb_cs_n      (epb_cs_n),
    .epb_r_w_n     (epb_r_w_n),
    .epb_oe_n      (epb_oe_n),
    .epb_be_n      (epb_be_n),
    .epb_addr      (epb_addr),
    .epb_addr_gp   (epb_addr_gp),
    .epb_data_i    (epb_data_i),
    .epb_data_o    (epb_data_o),
    .epb_data_oe_n (epb_data_oe_n),
    .epb_rdy       (epb_rdy),
    .m_request     (m0_request),
    .m_select      (m0_select),
    .m_rnw         (m0_rnw),
    .m_be          (m0_be),
    .m_abus        (m0_abus),
    .m_dbus        (m0_dbus),
    .opb_mgrant    (m0_mgrant),
    .opb_xferack   (opb_xferack),
    .opb_errack    (opb_errack),
    .opb_timeout   (opb_timeout),
    .opb_dbus      (opb_dbus)
  );

  opb_arbiter u_arbiter (
    .OPB_Clk     (OPB_Clk),
    .arst_n      (arst_n),
    .m0_request  (m0_request),
    .m0_select   (m0_select),
    .m0_rnw      (m0_rnw),
    .m0_be       (m0_be),
    .m0_abus     (m0_abus),
    .m0_dbus     (m0_dbus),
    .m0_mgrant   (m0_mgrant),
    .m1_request  (m1_request),
    .m1_select   (m1_select),
    .m1_rnw      (m1_rnw),
    .m1_be       (m1_be),
    .m1_abus     (m1_abus),
    .m1_dbus     (m1_dbus),
    .m1_mgrant   (m1_mgrant),
    .slv_xferack (slv_xferack),
    .slv_errack  (slv_errack),
    .slv_dbus    (slv_dbus),
    .bus_select  (bus_select),
    .bus_rnw     (bus_rnw),
    .bus_be      (bus_be),
    .bus_abus    (bus_abus),
    .bus_dbus    (bus_dbus),
    .opb_xferack (opb_xferack),
    .opb_errack  (opb_errack),
    .opb_dbus    (opb_dbus),
    .opb_timeout (opb_timeout)
  );

  opb_reg_slave u_slave (
    .OPB_Clk     (OPB_Clk),
    .arst_n      (arst_n),
    .bus_select  (bus_select),
    .bus_rnw     (bus_rnw),
    .bus_be      (bus_be),
    .bus_abus    (bus_abus),
    .bus_dbus    (bus_dbus),
    .slv_xferack (slv_xferack),
    .slv_errack  (slv_errack),
    .slv_dbus    (slv_dbus)
  );

endmodule

`default_nettype wire

//--- dv/epb_opb_chk.sv
`timescale 1ns/1ps
`default_nettype none

module epb_opb_chk (
  input wire OPB_Clk,
  input wire arst_n,
  input wire m0_mgrant,
  input wire m1_mgrant,
  input wire m0_select,
  input wire m1_select,
  input wire slv_xferack,
  input wire slv_errack,
  input wire opb_timeout
);

  // grant holds still while a master is on the bus
  a_grant_kept: assert property (@(posedge OPB_Clk) disable iff (!arst_n)
    (m0_select || m1_select) |=> $stable({m0_mgrant, m1_mgrant}))
    else $error("grant moved while a master held select");

  // a master on the bus must own the grant
  a_m0_sel_grant: assert property (@(posedge OPB_Clk) disable iff (!arst_n)
    m0_select |-> m0_mgrant)
    else $error("master 0 select without grant");

  a_m1_sel_grant: assert property (@(posedge OPB_Clk) disable iff (!arst_n)
    m1_select |-> m1_mgrant)
    else $error("master 1 select without grant");

  a_ack_excl: assert property (@(posedge OPB_Clk) disable iff (!arst_n)
    !(slv_xferack && slv_errack))
    else $error("xferAck and errAck together");

  // timeout lasts a single cycle
  a_timeout_pulse: assert property (@(posedge OPB_Clk) disable iff (!arst_n)
    opb_timeout |=> !opb_timeout)
    else $error("timeout held longer than one cycle");

endmodule

bind opb_arbiter epb_opb_chk u_chk (
  .OPB_Clk     (OPB_Clk),
  .arst_n      (arst_n),
  .m0_mgrant   (m0_mgrant),
  .m1_mgrant   (m1_mgrant),
  .m0_select   (m0_select),
  .m1_select   (m1_select),
  .slv_xferack (slv_xferack),
  .slv_errack  (slv_errack),
  .opb_timeout (opb_timeout)
);

`default_nettype wire

//--- dv/epb_opb_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "epb_opb_params.svh"

module epb_opb_tb;

  logic        OPB_Clk;
  logic        arst_n;
  logic        epb_cs_n;
  logic        epb_r_w_n;
  logic        epb_oe_n;
  logic [1:0]  epb_be_n;
  logic [22:0] epb_addr;
  logic [5:0]  epb_addr_gp;
  logic [15:0] epb_data_i;
  logic [15:0] epb_data_o;
  logic        epb_data_oe_n;
  logic        epb_rdy;
  logic        m1_request;
  logic        m1_select;
  logic        m1_rnw;
  logic [3:0]  m1_be;
  logic [31:0] m1_abus;
  logic [31:0] m1_dbus;
  logic        m1_mgrant;
  logic        m1_xferack;
  logic        m1_errack;
  logic        m1_timeout;
  logic [31:0] m1_dbus_rd;

  // shadow of the register bank
  // byte k of a word is data[8k+7:8k]
  logic [31:0] shadow [`REG_DEPTH];
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];
  string       what_q [$];

  epb_opb_top dut (.*);

  always #2 OPB_Clk = ~OPB_Clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp));
    end
  endtask

  function automatic void push_compare(input logic [31:0] got, input logic [31:0] exp,
                                       input string what);
    got_q.push_back(got);
    exp_q.push_back(exp);
    what_q.push_back(what);
  endfunction

  function automatic void shadow_write(input int unsigned word, input logic [3:0] be,
                                       input logic [31:0] data);
    if (word < `REG_DEPTH) begin
      for (int k = 0; k < 4; k++) begin
        if (be[k]) begin
          shadow[word][8*k +: 8] = data[8*k +: 8];
        end
      end
    end
  endfunction

  // unmapped words read back as zero
  function automatic logic [31:0] expect_word(input int unsigned word);
    if (word >= `REG_DEPTH) begin
      return 32'h0;
    end
    return shadow[word];
  endfunction

  // region 0 reply as {xferAck, errAck, timeout}
  function automatic logic [2:0] expect_reply(input int unsigned word);
    if (word >= `REG_DEPTH) begin
      return 3'b010;
    end
    return 3'b100;
  endfunction

  task automatic epb_access(input logic [5:0] gp, input int unsigned word, input logic odd,
                            input logic rnw, input logic [1:0] be_n, input logic [15:0] wdata,
                            output logic [15:0] rdata, output int cycles);
    @(posedge OPB_Clk);
    epb_cs_n    <= 1'b0;
    epb_r_w_n   <= rnw;
    epb_oe_n    <= rnw ? 1'b0 : 1'($urandom_range(1));
    epb_be_n    <= be_n;
    epb_addr    <= {22'(word), odd};
    epb_addr_gp <= gp;
    epb_data_i  <= wdata;
    cycles = 0;
    do begin
      @(posedge OPB_Clk);
      cycles++;
      if (cycles > 100) begin
        abort_run("EPB access saw no rdy within 100 cycles");
      end
    end while (!epb_rdy);
    rdata = epb_data_o;
    epb_cs_n <= 1'b1;
    epb_oe_n <= 1'b1;
  endtask

  task automatic epb_write(input logic [5:0] gp, input int unsigned word, input logic odd,
                           input logic [1:0] be_n, input logic [15:0] data);
    logic [15:0] rd;
    int          cyc;
    epb_access(gp, word, odd, 1'b0, be_n, data, rd, cyc);
    if (gp == 6'd0) begin
      shadow_write(word, odd ? {2'b00, ~be_n} : {~be_n, 2'b00},
                   odd ? {16'h0, data} : {data, 16'h0});
    end
  endtask

  task automatic epb_read(input logic [5:0] gp, input int unsigned word, input logic odd,
                          input string what);
    logic [15:0] rd;
    logic [31:0] exp;
    int          cyc;
    epb_access(gp, word, odd, 1'b1, 2'b00, 16'h0, rd, cyc);
    exp = (gp == 6'd0) ? expect_word(word) : 32'h0;
    push_compare({16'h0, rd}, {16'h0, odd ? exp[15:0] : exp[31:16]}, what);
  endtask

  task automatic m1_access(input logic [31:0] abus, input logic rnw, input logic [3:0] be,
                           input logic [31:0] wdata, input logic [2:0] exp_reply,
                           output logic [31:0] rdata);
    int cyc;
    @(posedge OPB_Clk);
    m1_request <= 1'b1;
    cyc = 0;
    do begin
      @(posedge OPB_Clk);
      cyc++;
      if (cyc > 200) begin
        abort_run("master 1 got no grant within 200 cycles");
      end
    end while (!m1_mgrant);
    m1_select <= 1'b1;
    m1_rnw    <= rnw;
    m1_be     <= be;
    m1_abus   <= abus;
    m1_dbus   <= rnw ? 32'h0 : wdata;
    cyc = 0;
    do begin
      @(posedge OPB_Clk);
      cyc++;
      if (cyc > 100) begin
        abort_run("master 1 got no reply within 100 cycles");
      end
    end while (!(m1_xferack || m1_errack || m1_timeout));
    check_value({29'h0, m1_xferack, m1_errack, m1_timeout}, {29'h0, exp_reply},
                "master 1 reply kind");
    rdata = m1_dbus_rd;
    // off the bus in the cycle after the reply
    m1_request <= 1'b0;
    m1_select  <= 1'b0;
    m1_rnw     <= 1'b0;
    m1_be      <= 4'h0;
    m1_abus    <= 32'h0;
    m1_dbus    <= 32'h0;
  endtask

  task automatic m1_write(input int unsigned word, input logic [3:0] be, input logic [31:0] data);
    logic [31:0] rd;
    m1_access(32'(word) << 2, 1'b0, be, data, expect_reply(word), rd);
    shadow_write(word, be, data);
  endtask

  task automatic m1_read(input int unsigned word, input string what);
    logic [31:0] rd;
    m1_access(32'(word) << 2, 1'b1, 4'hf, 32'h0, expect_reply(word), rd);
    push_compare(rd, expect_word(word), what);
  endtask

  // starts a write while master 1 is on the bus and gives up before the grant
  task automatic epb_abandon(input int unsigned word, input logic [15:0] wdata);
    int cyc;
    cyc = 0;
    do begin
      @(posedge OPB_Clk);
      cyc++;
      if (cyc > 100) begin
        abort_run("master 1 never raised select");
      end
    end while (!m1_select);
    epb_cs_n    <= 1'b0;
    epb_r_w_n   <= 1'b0;
    epb_oe_n    <= 1'b1;
    epb_be_n    <= 2'b00;
    epb_addr    <= {22'(word), 1'b0};
    epb_addr_gp <= 6'd0;
    epb_data_i  <= wdata;
    repeat (4) begin
      @(posedge OPB_Clk);
      check_value({31'h0, epb_rdy}, 32'h0, "rdy during abandoned write");
    end
    epb_cs_n <= 1'b1;
  endtask

  // compares queued read results and watches the data pin direction
  always @(posedge OPB_Clk) begin
    if (arst_n) begin
      check_value({31'h0, epb_data_oe_n},
                  {31'h0, !(!epb_cs_n && epb_r_w_n && !epb_oe_n)}, "data_oe_n");
    end
    while (got_q.size() > 0) begin
      check_value(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
    end
  end

  initial begin
    logic [31:0] rd32;
    logic [15:0] rd16;
    int          cyc;
    void'($urandom(50));
    OPB_Clk     = 1'b0;
    arst_n      = 1'b0;
    epb_cs_n    = 1'b1;
    epb_r_w_n   = 1'b1;
    epb_oe_n    = 1'b1;
    epb_be_n    = 2'b11;
    epb_addr    = '0;
    epb_addr_gp = '0;
    epb_data_i  = '0;
    m1_request  = 1'b0;
    m1_select   = 1'b0;
    m1_rnw      = 1'b0;
    m1_be       = '0;
    m1_abus     = '0;
    m1_dbus     = '0;
    for (int w = 0; w < `REG_DEPTH; w++) begin
      shadow[w] = 32'h0;
    end
    repeat (10) @(posedge OPB_Clk);
    arst_n <= 1'b1;

    // random half-word writes in region 0 and then read everything back
    for (int i = 0; i < 40; i++) begin
      epb_write(6'd0, $urandom_range(`REG_DEPTH - 1), 1'($urandom_range(1)),
                2'($urandom_range(3)), 16'($urandom));
    end
    for (int w = 0; w < `REG_DEPTH; w++) begin
      epb_read(6'd0, w, 1'b0, "EPB read upper half");
      epb_read(6'd0, w, 1'b1, "EPB read lower half");
    end

    // word past the bank answers with errAck and alias word 3 stays put
    epb_write(6'd0, `REG_DEPTH + 3, 1'b0, 2'b00, 16'hdead);
    epb_read(6'd0, `REG_DEPTH + 3, 1'b0, "EPB read past the bank");
    epb_read(6'd0, 3, 1'b0, "word 3 after write past the bank");
    epb_read(6'd0, 3, 1'b1, "word 3 after write past the bank");

    // other region has no slave so only the bus timeout ends it
    epb_access(6'd5, 7, 1'b0, 1'b0, 2'b00, 16'hbeef, rd16, cyc);
    check_value(32'(cyc - 1 >= `OPB_TIMEOUT_CYC), 32'h1, "rdy before the bus timeout");
    epb_read(6'd5, 7, 1'b1, "EPB read in region 5");
    epb_read(6'd0, 7, 1'b0, "word 7 after region 5 write");

    // master 1 owns words 32 and up and the EPB host the words below
    fork
      begin
        for (int i = 0; i < 16; i++) begin
          m1_write(32 + i, 4'($urandom_range(15)), $urandom);
          m1_read(32 + $urandom_range(i), "master 1 read");
        end
      end
      begin
        for (int i = 0; i < 16; i++) begin
          epb_write(6'd0, $urandom_range(31), 1'($urandom_range(1)),
                    2'($urandom_range(3)), 16'($urandom));
          epb_read(6'd0, $urandom_range(31), 1'($urandom_range(1)), "EPB read beside master 1");
        end
      end
    join
    for (int w = 0; w < 32; w++) begin
      m1_read(w, "master 1 read of EPB word");
    end
    for (int w = 32; w < `REG_DEPTH; w++) begin
      epb_read(6'd0, w, 1'b0, "EPB read of master 1 word");
      epb_read(6'd0, w, 1'b1, "EPB read of master 1 word");
    end

    // abandoned write while master 1 waits out a timeout
    fork
      m1_access(32'h0200_0010, 1'b1, 4'hf, 32'h0, 3'b001, rd32);
      epb_abandon(5, 16'h5a5a);
    join
    push_compare(rd32, 32'h0, "master 1 read after timeout");
    epb_read(6'd0, 5, 1'b0, "word 5 after abandoned write");
    epb_write(6'd0, 5, 1'b0, 2'b00, 16'h1234);
    epb_read(6'd0, 5, 1'b0, "word 5 after normal write");

    cyc = 0;
    while (got_q.size() > 0) begin
      @(posedge OPB_Clk);
      cyc++;
      if (cyc > 10) begin
        abort_run("compare queue did not drain");
      end
    end
    @(posedge OPB_Clk);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- epb_opb_top.f
+incdir+hdl
hdl/epb_opb_pkg.sv
hdl/epb_opb_bridge.sv
hdl/opb_arbiter.sv
hdl/opb_reg_slave.sv
hdl/epb_opb_top.sv
dv/epb_opb_chk.sv
dv/epb_opb_tb.sv
